// ==== logic/raster_settings.svh ====
`ifndef RASTER_SETTINGS_SVH
`define RASTER_SETTINGS_SVH

// Bits per color channel
`define SUB_PIXEL_WIDTH 8

// Channels per pixel, RGBA with red in the top byte and alpha in the lowest
`define NUMBER_OF_SUB_PIXEL 4

// Width of one whole color
`define PIXEL_WIDTH (`SUB_PIXEL_WIDTH * `NUMBER_OF_SUB_PIXEL)

// Cycles from fragment strobe to pixel strobe
`define BLEND_LATENCY 3

`endif

// ==== logic/rasterPkg.sv ====
package rasterPkg;

    // Blend factor opcodes
    // Codes 10 to 15 are not defined and must never reach the factor select
    typedef enum logic [3:0]
    {
        // Factor of zero on every channel
        ZERO                = 4'd0,
        // Full scale on every channel
        ONE                 = 4'd1,
        // Per channel source color
        SRC_COLOR           = 4'd2,
        ONE_MINUS_SRC_COLOR = 4'd3,
        // Per channel destination color
        DST_COLOR           = 4'd4,
        ONE_MINUS_DST_COLOR = 4'd5,
        // Source alpha replicated to all channels
        SRC_ALPHA           = 4'd6,
        ONE_MINUS_SRC_ALPHA = 4'd7,
        // Destination alpha replicated to all channels
        DST_ALPHA           = 4'd8,
        ONE_MINUS_DST_ALPHA = 4'd9
    } blendFactor_t;

endpackage

// ==== logic/BlendFactorSelect.sv ====
`include "raster_settings.svh"

// Decodes a blend factor opcode into a four channel factor color
// and registers it together with the color the factor multiplies
module BlendFactorSelect
    import rasterPkg::*;
#(
    // Set for the source side, cleared for the destination side
    parameter bit IS_SOURCE = 1'b1
)
(
    input  logic                        aclk,

    input  logic [`PIXEL_WIDTH - 1 : 0] srcColor,
    input  logic [`PIXEL_WIDTH - 1 : 0] dstColor,
    input  blendFactor_t                factor,

    output logic [`PIXEL_WIDTH - 1 : 0] factorColor,
    output logic [`PIXEL_WIDTH - 1 : 0] operand
);
    localparam int SUB = `SUB_PIXEL_WIDTH;
    localparam int NUM = `NUMBER_OF_SUB_PIXEL;

    // Full scale of one channel, stands for 1.0
    localparam logic [SUB - 1 : 0] FULL = '1;

    // Alpha sits in the lowest channel
    logic [SUB - 1 : 0] srcAlpha;
    logic [SUB - 1 : 0] dstAlpha;

    logic [`PIXEL_WIDTH - 1 : 0] nextFactor;

    assign srcAlpha = srcColor[SUB - 1 : 0];
    assign dstAlpha = dstColor[SUB - 1 : 0];

    for (genvar i = 0; i < NUM; i++)
    begin : gChannel
        logic [SUB - 1 : 0] srcSub;
        logic [SUB - 1 : 0] dstSub;
        logic [SUB - 1 : 0] channelFactor;

        assign srcSub = srcColor[i * SUB +: SUB];
        assign dstSub = dstColor[i * SUB +: SUB];

        always_comb
        begin
            case (factor)
                ZERO:
                    channelFactor = '0;
                ONE:
                    channelFactor = FULL;
                SRC_COLOR:
                    channelFactor = srcSub;
                ONE_MINUS_SRC_COLOR:
                    channelFactor = FULL - srcSub;
                DST_COLOR:
                    channelFactor = dstSub;
                ONE_MINUS_DST_COLOR:
                    channelFactor = FULL - dstSub;
                // Alpha factors apply the same alpha to every channel
                SRC_ALPHA:
                    channelFactor = srcAlpha;
                ONE_MINUS_SRC_ALPHA:
                    channelFactor = FULL - srcAlpha;
                DST_ALPHA:
                    channelFactor = dstAlpha;
                ONE_MINUS_DST_ALPHA:
                    channelFactor = FULL - dstAlpha;
                default:
                    channelFactor = '0;
            endcase
        end

        assign nextFactor[i * SUB +: SUB] = channelFactor;
    end

    // Factor and operand leave together so the mixer sees matching pairs
    always_ff @(posedge aclk)
    begin
        factorColor <= nextFactor;
        operand     <= IS_SOURCE ? srcColor : dstColor;
    end

    // The opcode comes from the configuration held in the top level
    factorLegal : assert property (
        @(posedge aclk) !$isunknown(factor) |-> (factor <= ONE_MINUS_DST_ALPHA)
    )
        else $error("BlendFactorSelect: illegal factor opcode %0d", factor);

endmodule

// ==== logic/ColorMixer.sv ====
`include "raster_settings.svh"

// Computes colorA * colorB + colorC * colorD per channel
// Stage 1 holds the products, stage 2 adds, rounds and saturates
module ColorMixer
(
    input  logic                        aclk,

    input  logic [`PIXEL_WIDTH - 1 : 0] colorA,
    input  logic [`PIXEL_WIDTH - 1 : 0] colorB,
    input  logic [`PIXEL_WIDTH - 1 : 0] colorC,
    input  logic [`PIXEL_WIDTH - 1 : 0] colorD,

    output logic [`PIXEL_WIDTH - 1 : 0] mixedColor
);
    localparam int SUB = `SUB_PIXEL_WIDTH;
    localparam int NUM = `NUMBER_OF_SUB_PIXEL;

    // Rounding constant, one channel full scale below the binary point
    localparam logic [2 * SUB : 0] ROUNDING = {{(SUB + 1){1'b0}}, {SUB{1'b1}}};

    // Drops the fraction and clamps anything above full scale
    function automatic logic [SUB - 1 : 0] saturate(input logic [2 * SUB : 0] sum);
        logic [SUB : 0] scaled;
        scaled = sum[2 * SUB : SUB];
        if (scaled[SUB])
            return '1;
        return scaled[SUB - 1 : 0];
    endfunction

    // Stage 1 products
    logic [2 * SUB - 1 : 0] productAB [NUM];
    logic [2 * SUB - 1 : 0] productCD [NUM];

    // One bit wider than a product to hold the carry of the add
    logic [2 * SUB : 0] channelSum [NUM];

    always_ff @(posedge aclk)
    begin
        for (int i = 0; i < NUM; i++)
        begin
            productAB[i] <= colorA[i * SUB +: SUB] * colorB[i * SUB +: SUB];
            productCD[i] <= colorC[i * SUB +: SUB] * colorD[i * SUB +: SUB];
        end
    end

    always_comb
    begin
        for (int i = 0; i < NUM; i++)
            channelSum[i] = {1'b0, productAB[i]} + {1'b0, productCD[i]} + ROUNDING;
    end

    // Stage 2
    always_ff @(posedge aclk)
    begin
        for (int i = 0; i < NUM; i++)
            mixedColor[i * SUB +: SUB] <= saturate(channelSum[i]);
    end

    logic inputsZero;

    assign inputsZero = ~|{colorA, colorB, colorC, colorD};

    // Rounding must not lift a black input above zero
    zeroStaysZero : assert property (
        @(posedge aclk) (inputsZero ##1 inputsZero) |=>
            (mixedColor == '0) ##1 (mixedColor == '0)
    )
        else $error("ColorMixer: zero inputs gave nonzero output %h", mixedColor);

endmodule

// ==== logic/ColorBlender.sv ====
`include "raster_settings.svh"

// Framebuffer blend stage
// pixelColor = src * srcFactor + dst * dstFactor, or src when blending is off
module ColorBlender
    import rasterPkg::*;
(
    input  logic                        aclk,
    input  logic                        reset,

    // Fragment in
    input  logic                        fragValid,
    input  logic [`PIXEL_WIDTH - 1 : 0] srcColor,
    input  logic [`PIXEL_WIDTH - 1 : 0] dstColor,
    input  logic                        blendEnable,

    // Blend configuration
    input  logic                        confValid,
    input  blendFactor_t                confSrcFactor,
    input  blendFactor_t                confDstFactor,

    // Pixel out, BLEND_LATENCY cycles after the fragment
    output logic                        pixelValid,
    output logic [`PIXEL_WIDTH - 1 : 0] pixelColor
);
    localparam int LAT = `BLEND_LATENCY;

    // Held configuration
    blendFactor_t srcFactor;
    blendFactor_t dstFactor;

    // Registered factor select outputs
    logic [`PIXEL_WIDTH - 1 : 0] srcOperand;
    logic [`PIXEL_WIDTH - 1 : 0] srcFactorColor;
    logic [`PIXEL_WIDTH - 1 : 0] dstOperand;
    logic [`PIXEL_WIDTH - 1 : 0] dstFactorColor;

    logic [`PIXEL_WIDTH - 1 : 0] mixedColor;

    // Side band that runs alongside the datapath
    logic [LAT - 1 : 0]          validPipe;
    logic [LAT - 1 : 0]          enablePipe;
    logic [`PIXEL_WIDTH - 1 : 0] colorPipe [LAT];

    // A new configuration takes effect from the next fragment on,
    // a fragment in the same cycle still uses the old one
    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            // Source passes straight through after reset
            srcFactor <= ONE;
            dstFactor <= ZERO;
        end
        else if (confValid)
        begin
            srcFactor <= confSrcFactor;
            dstFactor <= confDstFactor;
        end
    end

    BlendFactorSelect #(
        .IS_SOURCE   (1'b1)
    ) srcFactorSelect (
        .aclk        (aclk),
        .srcColor    (srcColor),
        .dstColor    (dstColor),
        .factor      (srcFactor),
        .factorColor (srcFactorColor),
        .operand     (srcOperand)
    );

    BlendFactorSelect #(
        .IS_SOURCE   (1'b0)
    ) dstFactorSelect (
        .aclk        (aclk),
        .srcColor    (srcColor),
        .dstColor    (dstColor),
        .factor      (dstFactor),
        .factorColor (dstFactorColor),
        .operand     (dstOperand)
    );

    ColorMixer mixer (
        .aclk       (aclk),
        .colorA     (srcOperand),
        .colorB     (srcFactorColor),
        .colorC     (dstOperand),
        .colorD     (dstFactorColor),
        .mixedColor (mixedColor)
    );

    // Valid strobes
    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            validPipe <= '0;
        end
        else
        begin
            validPipe[0] <= fragValid;
            for (int i = 1; i < LAT; i++)
                validPipe[i] <= validPipe[i - 1];
        end
    end

    // Bypass select and bypass color
    always_ff @(posedge aclk)
    begin
        enablePipe[0] <= blendEnable;
        colorPipe[0]  <= srcColor;
        for (int i = 1; i < LAT; i++)
        begin
            enablePipe[i] <= enablePipe[i - 1];
            colorPipe[i]  <= colorPipe[i - 1];
        end
    end

    assign pixelValid = validPipe[LAT - 1];
    assign pixelColor = enablePipe[LAT - 1] ? mixedColor : colorPipe[LAT - 1];

    // Every fragment leaves exactly BLEND_LATENCY cycles after it entered
    validLatency : assert property (
        @(posedge aclk) (!reset [*`BLEND_LATENCY]) |=>
            (pixelValid == $past(fragValid, `BLEND_LATENCY))
    )
        else $error("ColorBlender: pixelValid out of step with fragValid");

endmodule

// ==== bench/ClockGen.sv ====
// Free running clock for the testbench
module ClockGen
#(
    parameter int PERIOD = 4
)
(
    output logic aclk
);
    initial
    begin
        aclk = 1'b0;
    end

    always
    begin
        #(PERIOD / 2);
        aclk = ~aclk;
    end

endmodule

// ==== bench/ColorBlenderTb.sv ====
`include "raster_settings.svh"

module ColorBlenderTb
    import rasterPkg::*;
();
    localparam int SUB       = `SUB_PIXEL_WIDTH;
    localparam int NUM       = `NUMBER_OF_SUB_PIXEL;
    localparam int FULL      = (1 << SUB) - 1;
    localparam int MAX_CYCLE = 5000;

    logic                        aclk;
    logic                        reset;
    logic                        fragValid;
    logic [`PIXEL_WIDTH - 1 : 0] srcColor;
    logic [`PIXEL_WIDTH - 1 : 0] dstColor;
    logic                        blendEnable;
    logic                        confValid;
    blendFactor_t                confSrcFactor;
    blendFactor_t                confDstFactor;
    logic                        pixelValid;
    logic [`PIXEL_WIDTH - 1 : 0] pixelColor;

    // Configuration as the model sees it
    blendFactor_t modelSrc;
    blendFactor_t modelDst;

    // Expected colors and the cycle each fragment went in
    logic [`PIXEL_WIDTH - 1 : 0] expectQ [$];
    int                          cycleQ [$];
    logic [`PIXEL_WIDTH - 1 : 0] expected;
    int                          sentCycle;

    int cycleCount;
    int errorCount;

    ClockGen #(.PERIOD(4)) clockGen (.aclk(aclk));

    ColorBlender i_dut (
        .aclk          (aclk),
        .reset         (reset),
        .fragValid     (fragValid),
        .srcColor      (srcColor),
        .dstColor      (dstColor),
        .blendEnable   (blendEnable),
        .confValid     (confValid),
        .confSrcFactor (confSrcFactor),
        .confDstFactor (confDstFactor),
        .pixelValid    (pixelValid),
        .pixelColor    (pixelColor)
    );

    function automatic logic [`PIXEL_WIDTH - 1 : 0] randomColor();
        return `PIXEL_WIDTH'($urandom());
    endfunction

    function automatic logic [`PIXEL_WIDTH - 1 : 0] brightColor();
        logic [`PIXEL_WIDTH - 1 : 0] color;
        for (int ch = 0; ch < NUM; ch++)
            color[ch * SUB +: SUB] = SUB'($urandom_range(FULL / 4, FULL));
        return color;
    endfunction

    // Factor of one channel as given by the opcode table
    function automatic int factorFor(input blendFactor_t op, input int s, input int d,
                                     input int sa, input int da);
        case (op)
            ZERO:                return 0;
            ONE:                 return FULL;
            SRC_COLOR:           return s;
            ONE_MINUS_SRC_COLOR: return FULL - s;
            DST_COLOR:           return d;
            ONE_MINUS_DST_COLOR: return FULL - d;
            SRC_ALPHA:           return sa;
            ONE_MINUS_SRC_ALPHA: return FULL - sa;
            DST_ALPHA:           return da;
            ONE_MINUS_DST_ALPHA: return FULL - da;
            default:             return 0;
        endcase
    endfunction

    function automatic logic [`PIXEL_WIDTH - 1 : 0] expectedColor(
        input logic [`PIXEL_WIDTH - 1 : 0] src, input logic [`PIXEL_WIDTH - 1 : 0] dst,
        input blendFactor_t sf, input blendFactor_t df, input logic en);
        logic [`PIXEL_WIDTH - 1 : 0] result;
        int s;
        int d;
        int sum;
        result = '0;
        if (!en)
            return src;
        for (int ch = 0; ch < NUM; ch++)
        begin
            s   = int'(src[ch * SUB +: SUB]);
            d   = int'(dst[ch * SUB +: SUB]);
            sum = s * factorFor(sf, s, d, int'(src[SUB - 1 : 0]), int'(dst[SUB - 1 : 0]))
                + d * factorFor(df, s, d, int'(src[SUB - 1 : 0]), int'(dst[SUB - 1 : 0]))
                + FULL;
            sum = sum >> SUB;
            if (sum > FULL)
                sum = FULL;
            result[ch * SUB +: SUB] = SUB'(sum);
        end
        return result;
    endfunction

    // Drives one clock of stimulus and updates the model to match
    task automatic applyCycle(input logic frag, input logic [`PIXEL_WIDTH - 1 : 0] src,
                              input logic [`PIXEL_WIDTH - 1 : 0] dst, input logic en,
                              input logic conf, input blendFactor_t cs, input blendFactor_t cd);
        @(posedge aclk);
        #1;
        fragValid     = frag;
        srcColor      = src;
        dstColor      = dst;
        blendEnable   = en;
        confValid     = conf;
        confSrcFactor = cs;
        confDstFactor = cd;
        if (frag)
        begin
            expectQ.push_back(expectedColor(src, dst, modelSrc, modelDst, en));
            cycleQ.push_back(cycleCount);
        end
        // Same cycle fragment keeps the old configuration
        if (conf)
        begin
            modelSrc = cs;
            modelDst = cd;
        end
    endtask

    task automatic sendFragment(input logic en);
        applyCycle(1'b1, randomColor(), randomColor(), en, 1'b0, modelSrc, modelDst);
    endtask

    task automatic setConfig(input blendFactor_t cs, input blendFactor_t cd);
        applyCycle(1'b0, randomColor(), randomColor(), 1'b1, 1'b1, cs, cd);
    endtask

    task automatic idleCycles(input int count);
        repeat (count)
            applyCycle(1'b0, randomColor(), randomColor(), 1'b0, 1'b0, ZERO, ZERO);
    endtask

    function automatic blendFactor_t randomFactor();
        return blendFactor_t'($urandom_range(0, 9));
    endfunction

    always @(posedge aclk)
    begin
        cycleCount++;
        if (cycleCount >= MAX_CYCLE)
        begin
            $display("Timeout after %0d cycles with %0d pixels still due",
                     cycleCount, expectQ.size());
            $display("Checks failed");
            $finish;
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge aclk)
    begin
        if (!reset && pixelValid)
        begin
            if (expectQ.size() == 0)
            begin
                $display("A pixel came out with no fragment waiting for it");
                errorCount++;
            end
            else
            begin
                expected  = expectQ.pop_front();
                sentCycle = cycleQ.pop_front();
                if (pixelColor !== expected)
                begin
                    $display("Fail pixelColor expected %h got %h", expected, pixelColor);
                    errorCount++;
                end
                if (cycleCount - sentCycle != `BLEND_LATENCY)
                begin
                    $display("A pixel came out %0d cycles after its fragment instead of %0d",
                             cycleCount - sentCycle, `BLEND_LATENCY);
                    errorCount++;
                end
            end
        end
    end

    initial
    begin
        void'($urandom(32'h2ba1_b2cc));
        cycleCount    = 0;
        errorCount    = 0;
        modelSrc      = ONE;
        modelDst      = ZERO;
        reset         = 1'b1;
        fragValid     = 1'b0;
        srcColor      = '0;
        dstColor      = '0;
        blendEnable   = 1'b0;
        confValid     = 1'b0;
        confSrcFactor = ZERO;
        confDstFactor = ZERO;
        repeat (10) @(posedge aclk);
        #1;
        reset = 1'b0;

        // Quiet after reset and then the default pass through
        idleCycles(20);
        repeat (50) sendFragment(1'b1);

        // Every opcode on both sides
        for (int i = 0; i < 10; i++)
        begin
            setConfig(blendFactor_t'(i), blendFactor_t'(9 - i));
            repeat (100) sendFragment(1'b1);
            setConfig(blendFactor_t'(i), blendFactor_t'((i + 3) % 10));
            repeat (100) sendFragment(1'b1);
        end

        // Saturation with ONE plus ONE
        setConfig(ONE, ONE);
        repeat (100)
            applyCycle(1'b1, brightColor(), brightColor(), 1'b1, 1'b0, ONE, ONE);

        // Black fragments with zero factors keep the mixer output at zero
        setConfig(ZERO, ZERO);
        repeat (4)
            applyCycle(1'b1, '0, '0, 1'b1, 1'b0, ZERO, ZERO);

        // Enabled and bypassed fragments back to back
        for (int i = 0; i < 4; i++)
        begin
            setConfig(randomFactor(), randomFactor());
            repeat (50) sendFragment(1'($urandom_range(0, 1)));
        end

        // Configuration change in the same cycle as a fragment
        repeat (20)
        begin
            applyCycle(1'b1, randomColor(), randomColor(), 1'b1, 1'b1,
                       randomFactor(), randomFactor());
            sendFragment(1'b1);
            idleCycles(1);
        end

        // Random gaps in the fragment stream
        repeat (300)
        begin
            if ($urandom_range(0, 1))
                sendFragment(1'($urandom_range(0, 3) != 0));
            else if ($urandom_range(0, 15) == 0)
                setConfig(randomFactor(), randomFactor());
            else
                idleCycles(1);
        end

        idleCycles(`BLEND_LATENCY + 3);
        if (expectQ.size() != 0)
        begin
            $display("%0d fragments never came out as pixels", expectQ.size());
            errorCount++;
        end

        $display("Errors: %0d after %0d cycles", errorCount, cycleCount);
        if (errorCount == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/rasterPkg.sv
logic/BlendFactorSelect.sv
logic/ColorMixer.sv
logic/ColorBlender.sv
bench/ClockGen.sv
bench/ColorBlenderTb.sv

// ==== Makefile ====
# Verilator build and run for the blend stage

VERILATOR ?= verilator
TOP       ?= ColorBlenderTb
RTL_TOP   ?= ColorBlender
FLIST     ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)
	$(VERILATOR) $(LINTFLAGS) +incdir+logic logic/rasterPkg.sv \
		logic/BlendFactorSelect.sv logic/ColorMixer.sv logic/ColorBlender.sv \
		--top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
